// File: bus_pkg.sv
package bus_pkg;

    //////////////////////////////
    // widths
    //////////////////////////////

    // one bus beat carries one data word
    localparam int BEAT_W     = 32;
    localparam int BEATS_MAX  = 4;
    localparam int NODE_W     = 4;
    localparam int PADR_W     = 15;
    localparam int IDX_W      = $clog2(BEATS_MAX);
    localparam int PKT_DATA_W = BEAT_W * BEATS_MAX;

    // beats in the packet minus one
    typedef logic [IDX_W-1:0] len_t;

    //////////////////////////////
    // packet and bus word
    //////////////////////////////

    // data holds beat 0 in the low word
    typedef struct packed {
        logic [PADR_W-1:0]     padr;
        logic [NODE_W-1:0]     dest;
        logic [NODE_W-1:0]     ret;
        logic                  rw;
        len_t                  len;
        logic [PKT_DATA_W-1:0] data;
    } pkt_t;

    // every beat repeats the full header
    // idx and last let the receiver place the word without a size field
    typedef struct packed {
        logic              valid;
        logic [PADR_W-1:0] padr;
        logic [BEAT_W-1:0] data;
        logic [NODE_W-1:0] ret;
        logic [NODE_W-1:0] dest;
        logic              rw;
        len_t              idx;
        logic              last;
    } beat_t;

    //////////////////////////////
    // serializer FSM
    //////////////////////////////

    // free -> request -> wait for grant -> send -> free
    typedef enum logic [1:0] {
        SER_FREE,
        SER_REQ,
        SER_WAIT_GNT,
        SER_SEND
    } ser_state_t;

endpackage

// File: bus_ser.sv
`timescale 1ns/1ps

module bus_ser #(
    parameter int NODE_ID = 0
) (
    input  logic           clk_bus,
    input  logic           rst_n,

    // packet load from the block
    input  logic           in_valid,
    input  bus_pkg::pkt_t  in_pkt,

    // handshake with the arbiter
    input  logic           ack,
    input  logic           grant,
    output logic           free,
    output logic           req,
    output logic           release_bus,

    // beat toward the bus mux
    output bus_pkg::beat_t beat_word
);
    import bus_pkg::*;

    ser_state_t state;
    ser_state_t state_nxt;
    pkt_t       pkt_q;
    len_t       beat_cnt;
    logic       load;
    logic       last_beat;

    // a load offered while busy is simply lost
    assign load      = in_valid && (state == SER_FREE);
    assign last_beat = (state == SER_SEND) && (beat_cnt == pkt_q.len);

    assign free        = (state == SER_FREE);
    assign req         = (state == SER_REQ) || (state == SER_WAIT_GNT);
    assign release_bus = last_beat;

    //////////////////////////////
    // FSM
    //////////////////////////////

    always_comb begin
        state_nxt = state;
        case (state)
            SER_FREE: begin
                if (load) begin
                    state_nxt = SER_REQ;
                end
            end
            SER_REQ: begin
                if (ack) begin
                    state_nxt = SER_WAIT_GNT;
                end
            end
            SER_WAIT_GNT: begin
                if (grant) begin
                    state_nxt = SER_SEND;
                end
            end
            SER_SEND: begin
                if (last_beat) begin
                    state_nxt = SER_FREE;
                end
            end
            default: begin
                state_nxt = SER_FREE;
            end
        endcase
    end

    always_ff @(posedge clk_bus or negedge rst_n) begin
        if (!rst_n) begin
            state    <= SER_FREE;
            beat_cnt <= '0;
        end else begin
            state <= state_nxt;
            // counter restarts on grant, steps once per sent beat
            if (state == SER_WAIT_GNT && grant) begin
                beat_cnt <= '0;
            end else if (state == SER_SEND) begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    // packet holding register
    always_ff @(posedge clk_bus) begin
        if (load) begin
            pkt_q <= in_pkt;
        end
    end

    //////////////////////////////
    // beat word
    //////////////////////////////

    always_comb begin
        beat_word = '0;
        if (state == SER_SEND) begin
            beat_word.valid = 1'b1;
            beat_word.padr  = pkt_q.padr;
            beat_word.data  = pkt_q.data[beat_cnt*BEAT_W +: BEAT_W];
            beat_word.ret   = pkt_q.ret;
            beat_word.dest  = pkt_q.dest;
            beat_word.rw    = pkt_q.rw;
            beat_word.idx   = beat_cnt;
            beat_word.last  = (beat_cnt == pkt_q.len);
        end
    end

    // the arbiter may only grant a source that already got its ack
    a_grant_after_ack: assert property (
        @(posedge clk_bus) disable iff (!rst_n)
        grant |-> (state == SER_WAIT_GNT || state == SER_SEND)
    ) else $error("bus_ser %0d: grant seen outside wait/send", NODE_ID);

endmodule

// File: bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter #(
    parameter int N_SRC = 2
) (
    input  logic                       clk_bus,
    input  logic                       rst_n,
    input  logic [N_SRC-1:0]           req,
    input  logic [N_SRC-1:0]           release_bus,
    input  bus_pkg::beat_t [N_SRC-1:0] src_word,
    output logic [N_SRC-1:0]           ack,
    output logic [N_SRC-1:0]           grant,
    output bus_pkg::beat_t             bus_word
);
    import bus_pkg::*;

    localparam int SRC_W = (N_SRC > 1) ? $clog2(N_SRC) : 1;

    logic [N_SRC-1:0] acked;
    logic [N_SRC-1:0] waiting;
    logic             busy;
    logic [SRC_W-1:0] owner;
    logic [SRC_W-1:0] ptr;
    logic             win_found;
    logic [SRC_W-1:0] win;
    logic             bus_open;
    beat_t            sel_word;

    //////////////////////////////
    // request acknowledge
    //////////////////////////////

    // acked follows req one cycle late, so ack fires once per request
    always_ff @(posedge clk_bus or negedge rst_n) begin
        if (!rst_n) begin
            ack   <= '0;
            acked <= '0;
        end else begin
            ack   <= req & ~acked;
            acked <= req;
        end
    end

    // only acknowledged requests compete
    assign waiting = req & acked;

    //////////////////////////////
    // round robin
    //////////////////////////////

    always_comb begin
        int cand;
        win_found = 1'b0;
        win       = '0;
        for (int k = 0; k < N_SRC; k++) begin
            cand = int'(ptr) + k;
            if (cand >= N_SRC) begin
                cand = cand - N_SRC;
            end
            if (!win_found && waiting[cand]) begin
                win_found = 1'b1;
                win       = cand[SRC_W-1:0];
            end
        end
    end

    // owner release frees the bus for a new grant in the same edge
    assign bus_open = !busy || (|(release_bus & grant));

    always_ff @(posedge clk_bus or negedge rst_n) begin
        if (!rst_n) begin
            busy  <= 1'b0;
            owner <= '0;
            ptr   <= '0;
        end else if (bus_open) begin
            busy <= win_found;
            if (win_found) begin
                owner <= win;
                ptr   <= (win == SRC_W'(N_SRC - 1)) ? '0 : win + 1'b1;
            end
        end
    end

    //////////////////////////////
    // grant and bus mux
    //////////////////////////////

    always_comb begin
        for (int i = 0; i < N_SRC; i++) begin
            grant[i] = busy && (owner == SRC_W'(i));
        end
    end

    assign sel_word = src_word[owner];
    assign bus_word = busy ? sel_word : '0;

    // a fresh grant only goes to a source still holding its request
    a_grant_to_req: assert property (
        @(posedge clk_bus) disable iff (!rst_n)
        (|(grant & ~$past(grant))) |-> (|(grant & req))
    ) else $error("bus_arbiter: grant to a source without request");

    // a serializer must only release a bus it owns
    a_release_owner: assert property (
        @(posedge clk_bus) disable iff (!rst_n)
        (|release_bus) |-> (release_bus == grant)
    ) else $error("bus_arbiter: release from a source without grant");

endmodule

// File: bus_des.sv
`timescale 1ns/1ps

module bus_des #(
    parameter int NODE_ID = 0
) (
    input  logic           clk_bus,
    input  logic           rst_n,
    input  bus_pkg::beat_t bus_word,
    output logic           out_valid,
    output bus_pkg::pkt_t  out_pkt
);
    import bus_pkg::*;

    localparam logic [NODE_W-1:0] MY_NODE = NODE_W'(NODE_ID);

    logic hit;
    logic hit_last;
    pkt_t asm_q;
    pkt_t asm_nxt;
    len_t exp_idx;

    // beats for other nodes pass by untouched
    assign hit      = bus_word.valid && (bus_word.dest == MY_NODE);
    assign hit_last = hit && bus_word.last;

    //////////////////////////////
    // assembly
    //////////////////////////////

    always_comb begin
        asm_nxt = asm_q;
        // beat 0 opens a new packet
        if (bus_word.idx == '0) begin
            asm_nxt.padr = bus_word.padr;
            asm_nxt.dest = bus_word.dest;
            asm_nxt.ret  = bus_word.ret;
            asm_nxt.rw   = bus_word.rw;
            asm_nxt.data = '0;
        end
        // len ends up as the idx of the last beat
        asm_nxt.len = bus_word.idx;
        asm_nxt.data[bus_word.idx*BEAT_W +: BEAT_W] = bus_word.data;
    end

    always_ff @(posedge clk_bus) begin
        if (hit) begin
            asm_q <= asm_nxt;
        end
        if (hit_last) begin
            out_pkt <= asm_nxt;
        end
    end

    //////////////////////////////
    // delivery strobe
    //////////////////////////////

    always_ff @(posedge clk_bus or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            exp_idx   <= '0;
        end else begin
            out_valid <= hit_last;
            if (hit) begin
                exp_idx <= bus_word.last ? '0 : bus_word.idx + 1'b1;
            end
        end
    end

    // beats of one packet arrive back to back and in order
    a_idx_order: assert property (
        @(posedge clk_bus) disable iff (!rst_n)
        hit |-> (bus_word.idx == exp_idx)
    ) else $error("bus_des %0d: beat idx %0d, expected %0d",
                  NODE_ID, bus_word.idx, exp_idx);

endmodule

// File: bus_subsystem_top.sv
`timescale 1ns/1ps

module bus_subsystem_top #(
    parameter int N_SRC = 2,
    parameter int N_DST = 2
) (
    input  logic                      clk_bus,
    input  logic                      rst_n,
    input  logic [N_SRC-1:0]          in_valid,
    input  bus_pkg::pkt_t [N_SRC-1:0] in_pkt,
    output logic [N_SRC-1:0]          free,
    output logic [N_DST-1:0]          out_valid,
    output bus_pkg::pkt_t [N_DST-1:0] out_pkt
);
    import bus_pkg::*;

    logic  [N_SRC-1:0] req;
    logic  [N_SRC-1:0] ack;
    logic  [N_SRC-1:0] grant;
    logic  [N_SRC-1:0] release_bus;
    beat_t [N_SRC-1:0] src_word;
    beat_t             bus_word;

    // one serializer per source
    for (genvar i = 0; i < N_SRC; i++) begin : g_ser
        bus_ser #(
            .NODE_ID(i)
        ) i_ser (
            .clk_bus    (clk_bus),
            .rst_n      (rst_n),
            .in_valid   (in_valid[i]),
            .in_pkt     (in_pkt[i]),
            .ack        (ack[i]),
            .grant      (grant[i]),
            .free       (free[i]),
            .req        (req[i]),
            .release_bus(release_bus[i]),
            .beat_word  (src_word[i])
        );
    end

    bus_arbiter #(
        .N_SRC(N_SRC)
    ) i_arbiter (
        .clk_bus    (clk_bus),
        .rst_n      (rst_n),
        .req        (req),
        .release_bus(release_bus),
        .src_word   (src_word),
        .ack        (ack),
        .grant      (grant),
        .bus_word   (bus_word)
    );

    // every deserializer watches the shared bus word
    for (genvar j = 0; j < N_DST; j++) begin : g_des
        bus_des #(
            .NODE_ID(j)
        ) i_des (
            .clk_bus  (clk_bus),
            .rst_n    (rst_n),
            .bus_word (bus_word),
            .out_valid(out_valid[j]),
            .out_pkt  (out_pkt[j])
        );
    end

endmodule

// File: tb_bus_subsystem.sv
`timescale 1ns/1ps

module tb_bus_subsystem;
    import bus_pkg::*;

    localparam int N_SRC       = 2;
    localparam int N_DST       = 2;
    localparam int CLK_PERIOD  = 4;
    localparam int N_RANDOM    = 200;
    // reset, contention, single, drop, random
    localparam int N_PKTS      = 1 + 5 + 16 + 2 + N_RANDOM;
    localparam int CYC_PER_PKT = 40;

    logic             clk_bus;
    logic             rst_n;
    logic [N_SRC-1:0] in_valid;
    pkt_t [N_SRC-1:0] in_pkt;
    logic [N_SRC-1:0] free;
    logic [N_DST-1:0] out_valid;
    pkt_t [N_DST-1:0] out_pkt;

    logic [31:0] lfsr;
    int          n_loaded;
    int          n_delivered;
    // expected packets per destination and source, arrivals per destination
    pkt_t        sent_q [N_DST][N_SRC][$];
    pkt_t        rx_q [N_DST][$];

    bus_subsystem_top #(
        .N_SRC(N_SRC),
        .N_DST(N_DST)
    ) i_dut (
        .clk_bus  (clk_bus),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .in_pkt   (in_pkt),
        .free     (free),
        .out_valid(out_valid),
        .out_pkt  (out_pkt)
    );

    always #(CLK_PERIOD / 2) clk_bus = ~clk_bus;

    //////////////////////////////
    // helpers
    //////////////////////////////

    // galois LFSR, one step per bit taken
    function automatic logic [PKT_DATA_W-1:0] rand_bits(input int n);
        logic [PKT_DATA_W-1:0] v;
        v = '0;
        for (int b = 0; b < n; b++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hd000_0001) : (lfsr >> 1);
            v[b] = lfsr[0];
        end
        return v;
    endfunction

    function automatic pkt_t rand_pkt(input int src, input int dst, input int len);
        pkt_t p;
        p.padr = PADR_W'(rand_bits(PADR_W));
        p.dest = NODE_W'(dst);
        // ret is the source tag
        p.ret  = NODE_W'(src);
        p.rw   = 1'(rand_bits(1));
        p.len  = len_t'(len);
        p.data = rand_bits(PKT_DATA_W);
        return p;
    endfunction

    // words above len are never sent, so they read back as zero
    function automatic pkt_t expected_of(input pkt_t p);
        pkt_t e;
        e = p;
        for (int w = 0; w < BEATS_MAX; w++) begin
            if (w > int'(p.len)) begin
                e.data[w*BEAT_W +: BEAT_W] = '0;
            end
        end
        return e;
    endfunction

    task automatic stop_with_failure();
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    task automatic check_pkt(input string name, input pkt_t exp, input pkt_t act);
        if (act !== exp) begin
            $display("Fail %s: expected %h actual %h", name, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Fail %s: expected %b actual %b", name, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic next_cycle();
        @(posedge clk_bus);
        #1;
    endtask

    task automatic record_sent(input pkt_t p);
        sent_q[p.dest][p.ret].push_back(expected_of(p));
        n_loaded++;
    endtask

    task automatic load_one(input int src, input pkt_t p);
        while (!free[src]) begin
            next_cycle();
        end
        in_valid[src] = 1'b1;
        in_pkt[src]   = p;
        record_sent(p);
        next_cycle();
        in_valid[src] = 1'b0;
    endtask

    // both sources in the same cycle
    task automatic load_pair(input pkt_t p0, input pkt_t p1);
        while (free != '1) begin
            next_cycle();
        end
        in_valid  = '1;
        in_pkt[0] = p0;
        in_pkt[1] = p1;
        record_sent(p0);
        record_sent(p1);
        next_cycle();
        in_valid = '0;
    endtask

    task automatic wait_delivered();
        while (n_delivered != n_loaded) begin
            next_cycle();
        end
    endtask

    // each arrival must be the oldest outstanding packet from its source
    task automatic drain_check(input string name);
        pkt_t got;
        pkt_t want;
        for (int d = 0; d < N_DST; d++) begin
            while (rx_q[d].size() > 0) begin
                got = rx_q[d].pop_front();
                if (got.ret >= N_SRC || sent_q[d][got.ret].size() == 0) begin
                    $display("%s: node %0d delivered a packet that was never sent", name, d);
                    stop_with_failure();
                end
                want = sent_q[d][got.ret].pop_front();
                check_pkt(name, want, got);
            end
        end
    endtask

    //////////////////////////////
    // monitor and watchdog
    //////////////////////////////

    always @(negedge clk_bus) begin
        if (rst_n) begin
            for (int d = 0; d < N_DST; d++) begin
                if (out_valid[d]) begin
                    rx_q[d].push_back(out_pkt[d]);
                    n_delivered++;
                end
            end
            if (n_delivered > n_loaded) begin
                $display("more packets delivered than loaded");
                stop_with_failure();
            end
        end
    end

    initial begin
        #(CLK_PERIOD * (10 + N_PKTS * CYC_PER_PKT));
        $display("watchdog: the tests did not finish in time");
        stop_with_failure();
    end

    //////////////////////////////
    // tests
    //////////////////////////////

    task automatic test_reset();
        for (int s = 0; s < N_SRC; s++) begin
            check_bit("test_reset free", 1'b1, free[s]);
        end
        for (int d = 0; d < N_DST; d++) begin
            check_bit("test_reset out_valid", 1'b0, out_valid[d]);
        end
    endtask

    task automatic test_contention();
        pkt_t p0;
        pkt_t p1;
        pkt_t lone;
        pkt_t q0;
        pkt_t q1;
        // pointer at 0 after reset
        p0 = rand_pkt(0, 0, 3);
        p1 = rand_pkt(1, 0, 1);
        load_pair(p0, p1);
        wait_delivered();
        check_pkt("test_contention first pair", expected_of(p0), rx_q[0][0]);
        drain_check("test_contention");
        // source 1 won last, pointer back at 0, lone source 0 moves it to 1
        lone = rand_pkt(0, 1, 0);
        load_one(0, lone);
        wait_delivered();
        drain_check("test_contention");
        q0 = rand_pkt(0, 1, 2);
        q1 = rand_pkt(1, 1, 3);
        load_pair(q0, q1);
        wait_delivered();
        check_pkt("test_contention second pair", expected_of(q1), rx_q[1][0]);
        drain_check("test_contention");
    endtask

    task automatic test_single();
        pkt_t p;
        for (int s = 0; s < N_SRC; s++) begin
            for (int d = 0; d < N_DST; d++) begin
                for (int len = 0; len < BEATS_MAX; len++) begin
                    p = rand_pkt(s, d, len);
                    load_one(s, p);
                    wait_delivered();
                    drain_check("test_single");
                    check_bit("test_single free", 1'b1, free[s]);
                end
            end
        end
    endtask

    task automatic test_drop();
        pkt_t kept;
        pkt_t lost;
        kept = rand_pkt(0, 1, 3);
        lost = rand_pkt(0, 0, 2);
        load_one(0, kept);
        check_bit("test_drop busy", 1'b0, free[0]);
        // no record, this load must vanish
        in_valid[0] = 1'b1;
        in_pkt[0]   = lost;
        next_cycle();
        in_valid[0] = 1'b0;
        wait_delivered();
        // room for a wrongly taken packet to show up
        repeat (CYC_PER_PKT) next_cycle();
        drain_check("test_drop");
    endtask

    task automatic test_random();
        int   n_gen;
        int   dst;
        int   len;
        pkt_t p;
        n_gen = 0;
        while (n_gen < N_RANDOM) begin
            for (int s = 0; s < N_SRC; s++) begin
                if (free[s] && n_gen < N_RANDOM) begin
                    dst = int'(rand_bits(1));
                    len = int'(rand_bits(2));
                    p   = rand_pkt(s, dst, len);
                    in_valid[s] = 1'b1;
                    in_pkt[s]   = p;
                    record_sent(p);
                    n_gen++;
                end
            end
            next_cycle();
            in_valid = '0;
        end
        wait_delivered();
        drain_check("test_random");
    endtask

    initial begin
        clk_bus     = 1'b0;
        rst_n       = 1'b0;
        in_valid    = '0;
        in_pkt      = '0;
        lfsr        = 32'hc62c_0556;
        n_loaded    = 0;
        n_delivered = 0;
        repeat (10) @(posedge clk_bus);
        #1;
        rst_n = 1'b1;
        test_reset();
        test_contention();
        test_single();
        test_drop();
        test_random();
        $display("=== PASS ===");
        $finish;
    end

endmodule

// File: build.f
bus_pkg.sv
bus_ser.sv
bus_arbiter.sv
bus_des.sv
bus_subsystem_top.sv
tb_bus_subsystem.sv
